//--- tb.f
common/lbls_pkg.sv
common/lbls_words_if.sv
verilog/lbls_word_conditioner.sv
verilog/lbls_channel_counters.sv
verilog/lbls_rate_scaler.sv
verilog/lbls_tot_accumulator.sv
verilog/lbls_bank.sv
test/lbls_bank_tb.sv

//--- Bender.yml
package:
  name: lbls_bank

dependencies: {}

sources:
  # shared package and interface
  - common/lbls_pkg.sv
  - common/lbls_words_if.sv

  # pipeline stages and top level
  - verilog/lbls_word_conditioner.sv
  - verilog/lbls_channel_counters.sv
  - verilog/lbls_rate_scaler.sv
  - verilog/lbls_tot_accumulator.sv
  - verilog/lbls_bank.sv

  # simulation only
  - target: test
    files:
      - test/lbls_bank_tb.sv

//--- test/lbls_bank_tb.sv
// testbench for one readout bank, drives lbls_bank through reset, counters,
// rate scalers, time over threshold and the any-hit flag
// expected values come from a popcount reference model of the conditioning rules
`default_nettype none

module lbls_bank_tb;

	// 20 cycle trigger window for the tot test
	localparam int TOT_CYCLES = 20;
	// about 720 cycles of tests, wide margin on top
	localparam int TIMEOUT_CYCLES = 3000;
	localparam logic [31:0] SCALER_MAX = (1 << lbls_pkg::SCALER_WIDTH) - 1;

	logic clock;
	logic reset;
	lbls_pkg::channel_words_t win;
	lbls_pkg::channel_mask_t hit_mask;
	lbls_pkg::channel_mask_t inversion_mask;
	logic gate;
	logic clear_channel_counters;
	logic trigger_active;
	logic [lbls_pkg::NUM_CHANNELS-1:0][lbls_pkg::COUNTER_WIDTH-1:0] counts;
	logic [lbls_pkg::NUM_CHANNELS-1:0][lbls_pkg::SCALER_WIDTH-1:0] scalers;
	logic [lbls_pkg::NUM_CHANNELS-1:0][lbls_pkg::TOT_WIDTH-1:0] tots;
	logic any;

	// bookkeeping
	int cycle_count = 0;
	int test_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	logic [31:0] rng = 32'hc3eea813;
	// predicted running counts per channel
	logic [31:0] expected_counts [lbls_pkg::NUM_CHANNELS];

	lbls_bank u_dut (
		.clock(clock),
		.reset(reset),
		.win(win),
		.hit_mask(hit_mask),
		.inversion_mask(inversion_mask),
		.gate(gate),
		.clear_channel_counters(clear_channel_counters),
		.trigger_active(trigger_active),
		.counts(counts),
		.scalers(scalers),
		.tots(tots),
		.any(any)
	);

	initial clock = 1'b0;
	always #5 clock = ~clock;

	// run limit
	always @(posedge clock) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// numerical recipes LCG
	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// ones of one word after polarity flip, zero when the channel is not enabled
	function automatic int ref_ones(input logic [7:0] word, input logic invert,
			input logic enable);
		logic [7:0] conditioned;
		int total;
		conditioned = (word ^ {8{invert}}) & {8{enable}};
		total = 0;
		for (int b = 0; b < 8; b++) begin
			if (conditioned[b]) begin
				total = total + 1;
			end
		end
		return total;
	endfunction

	// lands 1 unit after the last edge, where inputs change and outputs are settled
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clock);
		#1;
	endtask

	task automatic randomize_words();
		for (int ch = 0; ch < lbls_pkg::NUM_CHANNELS; ch++) begin
			rng = lcg_next(rng);
			win[ch] = rng[23:16];
		end
	endtask

	task automatic report_mismatch(input string signal, input logic [31:0] got,
			input logic [31:0] expected);
		$display("Fail %s: got 0x%h, expected 0x%h", signal, got, expected);
		test_errors = test_errors + 1;
	endtask

	// one summary line per test
	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			$display("Pass: %s", name);
			tests_passed = tests_passed + 1;
		end else begin
			$display("Fail: %s, %0d mismatches", name, test_errors);
			tests_failed = tests_failed + 1;
		end
		test_errors = 0;
	endtask

	initial begin : stimulus
		logic [31:0] expected;
		int pick;
		reset = 1'b1;
		win = '0;
		hit_mask = '0;
		inversion_mask = '0;
		gate = 1'b0;
		clear_channel_counters = 1'b0;
		trigger_active = 1'b0;
		wait_cycles(8);
		reset = 1'b0;

		// everything zero out of reset
		if (any !== 1'b0)
			report_mismatch("any", any, 0);
		for (int ch = 0; ch < lbls_pkg::NUM_CHANNELS; ch++) begin
			if (counts[ch] !== '0)
				report_mismatch($sformatf("counts[%0d]", ch), counts[ch], 0);
			if (scalers[ch] !== '0)
				report_mismatch($sformatf("scalers[%0d]", ch), scalers[ch], 0);
			if (tots[ch] !== '0)
				report_mismatch($sformatf("tots[%0d]", ch), tots[ch], 0);
		end
		finish_test("reset state");

		// counters follow every word, mask and gate stay closed
		clear_channel_counters = 1'b1;
		wait_cycles(1);
		clear_channel_counters = 1'b0;
		for (int ch = 0; ch < lbls_pkg::NUM_CHANNELS; ch++) begin
			expected_counts[ch] = 0;
		end
		for (int i = 0; i < 40; i++) begin
			randomize_words();
			rng = lcg_next(rng);
			inversion_mask = rng[27:16];
			for (int ch = 0; ch < lbls_pkg::NUM_CHANNELS; ch++) begin
				expected_counts[ch] = expected_counts[ch] +
					ref_ones(win[ch], inversion_mask[ch], 1'b1);
			end
			wait_cycles(1);
		end
		// zero words add nothing while the last ones settle
		win = '0;
		inversion_mask = '0;
		wait_cycles(3);
		for (int ch = 0; ch < lbls_pkg::NUM_CHANNELS; ch++) begin
			if (counts[ch] !== expected_counts[ch])
				report_mismatch($sformatf("counts[%0d]", ch), counts[ch],
					expected_counts[ch]);
		end
		clear_channel_counters = 1'b1;
		wait_cycles(1);
		clear_channel_counters = 1'b0;
		for (int ch = 0; ch < lbls_pkg::NUM_CHANNELS; ch++) begin
			if (counts[ch] !== '0)
				report_mismatch($sformatf("counts[%0d]", ch), counts[ch], 0);
		end
		finish_test("channel counters and clear");

		// steady input, so any complete window gives the same value
		randomize_words();
		rng = lcg_next(rng);
		inversion_mask = rng[27:16];
		wait_cycles(600);
		for (int ch = 0; ch < lbls_pkg::NUM_CHANNELS; ch++) begin
			expected = ref_ones(win[ch], inversion_mask[ch], 1'b1) *
				lbls_pkg::ACCUMULATE_PERIODS;
			if (expected > SCALER_MAX)
				expected = SCALER_MAX;
			if (scalers[ch] !== expected[lbls_pkg::SCALER_WIDTH-1:0])
				report_mismatch($sformatf("scalers[%0d]", ch), scalers[ch], expected);
		end
		finish_test("rate scaler");

		// tot with random enables and gate open
		randomize_words();
		rng = lcg_next(rng);
		hit_mask = rng[27:16];
		gate = 1'b1;
		trigger_active = 1'b1;
		wait_cycles(TOT_CYCLES);
		trigger_active = 1'b0;
		// publish lands three cycles after the fall
		wait_cycles(5);
		for (int ch = 0; ch < lbls_pkg::NUM_CHANNELS; ch++) begin
			expected = (ref_ones(win[ch], inversion_mask[ch], hit_mask[ch] & gate) *
				TOT_CYCLES) % (1 << lbls_pkg::TOT_WIDTH);
			if (tots[ch] !== expected[lbls_pkg::TOT_WIDTH-1:0])
				report_mismatch($sformatf("tots[%0d]", ch), tots[ch], expected);
		end
		// closed gate blocks every channel
		gate = 1'b0;
		trigger_active = 1'b1;
		wait_cycles(TOT_CYCLES);
		trigger_active = 1'b0;
		wait_cycles(5);
		for (int ch = 0; ch < lbls_pkg::NUM_CHANNELS; ch++) begin
			if (tots[ch] !== '0)
				report_mismatch($sformatf("tots[%0d]", ch), tots[ch], 0);
		end
		finish_test("time over threshold with mask and gate");

		// any-hit flag, quiet words first
		win = '0;
		inversion_mask = '0;
		gate = 1'b1;
		wait_cycles(4);
		if (any !== 1'b0)
			report_mismatch("any", any, 0);
		rng = lcg_next(rng);
		pick = rng[19:16] % lbls_pkg::NUM_CHANNELS;
		win[pick] = rng[31:24] | 8'h01;
		hit_mask = '0;
		hit_mask[pick] = 1'b1;
		wait_cycles(4);
		if (any !== 1'b1)
			report_mismatch("any", any, 1);
		gate = 1'b0;
		wait_cycles(4);
		if (any !== 1'b0)
			report_mismatch("any", any, 0);
		finish_test("any-hit flag");

		$display("tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog/lbls_bank.sv
// one readout bank of the photon detector trigger and DAQ board
// conditioner feeds counters, rate scalers and tot in parallel
// any is the registered OR of the per channel hit flags
`default_nettype none

module lbls_bank (
	input wire logic clock,
	input wire logic reset,
	// one deserializer word per channel per clock
	input wire lbls_pkg::channel_words_t win,
	input wire lbls_pkg::channel_mask_t hit_mask,
	input wire lbls_pkg::channel_mask_t inversion_mask,
	input wire logic gate,
	input wire logic clear_channel_counters,
	input wire logic trigger_active,
	// running ones counts since the last clear
	output logic [lbls_pkg::NUM_CHANNELS-1:0][lbls_pkg::COUNTER_WIDTH-1:0] counts,
	// once per window
	output logic [lbls_pkg::NUM_CHANNELS-1:0][lbls_pkg::SCALER_WIDTH-1:0] scalers,
	// once per trigger window
	output logic [lbls_pkg::NUM_CHANNELS-1:0][lbls_pkg::TOT_WIDTH-1:0] tots,
	// some gated enabled channel saw a nonzero word
	output logic any
);

	// conditioned words shared by all stages
	lbls_words_if words ();

	lbls_word_conditioner u_conditioner (
		.clock(clock),
		.reset(reset),
		.win(win),
		.inversion_mask(inversion_mask),
		.hit_mask(hit_mask),
		.gate(gate),
		.trigger_active(trigger_active),
		.words(words.source)
	);

	// monitoring counters on the unmasked inverted words
	lbls_channel_counters u_counters (
		.clock(clock),
		.reset(reset),
		.clear_channel_counters(clear_channel_counters),
		.words(words.sink),
		.counts(counts)
	);

	// rate scalers on the unmasked inverted words
	lbls_rate_scaler u_scaler (
		.clock(clock),
		.reset(reset),
		.words(words.sink),
		.scalers(scalers)
	);

	// tot on the masked ones and aligned trigger
	lbls_tot_accumulator u_tot (
		.clock(clock),
		.reset(reset),
		.words(words.sink),
		.tots(tots)
	);

	// hit lines up with masked at N+1
	// so any reflects the word from edge N at N+2
	always_ff @(posedge clock) begin
		if (reset) begin
			any <= 1'b0;
		end else begin
			any <= |words.hit;
		end
	end

endmodule

`default_nettype wire

//--- verilog/lbls_tot_accumulator.sv
// time over threshold per channel across each trigger window
// sums the masked ones while the aligned trigger is high
// publishes and clears on the first cycle after the trigger falls
`default_nettype none

module lbls_tot_accumulator (
	input wire logic clock,
	input wire logic reset,
	lbls_words_if.sink words,
	output logic [lbls_pkg::NUM_CHANNELS-1:0][lbls_pkg::TOT_WIDTH-1:0] tots
);

	// aligned trigger one cycle back, for edge detect
	logic trigger_prev;
	logic trigger_fell;

	// sums for the window in progress
	logic [lbls_pkg::NUM_CHANNELS-1:0][lbls_pkg::TOT_WIDTH-1:0] tot_sums;

	assign trigger_fell = trigger_prev && !words.trigger;

	always_ff @(posedge clock) begin
		if (reset) begin
			trigger_prev <= 1'b0;
		end else begin
			trigger_prev <= words.trigger;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			tot_sums <= '0;
			tots <= '0;
		end else begin
			for (int ch = 0; ch < lbls_pkg::NUM_CHANNELS; ch++) begin
				if (words.trigger) begin
					// wraps at TOT_WIDTH bits
					tot_sums[ch] <= tot_sums[ch] +
						(lbls_pkg::TOT_WIDTH)'(words.ones[ch]);
				end else if (trigger_fell) begin
					tots[ch] <= tot_sums[ch];
					tot_sums[ch] <= '0;
				end
			end
		end
	end

	// readout stays put for the whole trigger window
	a_tots_stable: assert property (
		@(posedge clock) disable iff (reset)
		words.trigger |=> $stable(tots)
	);

endmodule

`default_nettype wire

//--- verilog/lbls_rate_scaler.sv
// windowed rate scaler per channel
// sums inverted ones over ACCUMULATE_PERIODS clocks and publishes once per window
// published values saturate at the scaler maximum
`default_nettype none

module lbls_rate_scaler (
	input wire logic clock,
	input wire logic reset,
	lbls_words_if.sink words,
	output logic [lbls_pkg::NUM_CHANNELS-1:0][lbls_pkg::SCALER_WIDTH-1:0] scalers
);

	// position inside the current window
	logic [lbls_pkg::WINDOW_WIDTH-1:0] window_count;
	logic window_last;

	// running sums and their saturated next values
	logic [lbls_pkg::NUM_CHANNELS-1:0][lbls_pkg::SCALER_WIDTH-1:0] sums;
	logic [lbls_pkg::NUM_CHANNELS-1:0][lbls_pkg::SCALER_WIDTH-1:0] sum_next;
	// one extra bit to catch the overflow
	logic [lbls_pkg::NUM_CHANNELS-1:0][lbls_pkg::SCALER_WIDTH:0] sum_wide;

	assign window_last = (window_count ==
		(lbls_pkg::WINDOW_WIDTH)'(lbls_pkg::ACCUMULATE_PERIODS - 1));

	// window runs free from reset
	always_ff @(posedge clock) begin
		if (reset) begin
			window_count <= '0;
		end else if (window_last) begin
			window_count <= '0;
		end else begin
			window_count <= window_count + 1'b1;
		end
	end

	always_comb begin
		for (int ch = 0; ch < lbls_pkg::NUM_CHANNELS; ch++) begin
			sum_wide[ch] = {1'b0, sums[ch]} + (lbls_pkg::SCALER_WIDTH + 1)'(
				lbls_pkg::count_ones(words.inverted[ch]));
			// pin at all ones once the top bit carries
			sum_next[ch] = sum_wide[ch][lbls_pkg::SCALER_WIDTH] ?
				'1 : sum_wide[ch][lbls_pkg::SCALER_WIDTH-1:0];
		end
	end

	// last cycle includes its own word in the published value
	always_ff @(posedge clock) begin
		if (reset) begin
			sums <= '0;
			scalers <= '0;
		end else if (window_last) begin
			scalers <= sum_next;
			sums <= '0;
		end else begin
			sums <= sum_next;
		end
	end

	a_window_range: assert property (
		@(posedge clock) disable iff (reset)
		window_count < lbls_pkg::ACCUMULATE_PERIODS
	);

endmodule

`default_nettype wire

//--- verilog/lbls_channel_counters.sv
// running ones counter per channel for slow monitoring
// counts every inverted word regardless of mask and gate
// software reads the counts and then pulses the clear
`default_nettype none

module lbls_channel_counters (
	input wire logic clock,
	input wire logic reset,
	input wire logic clear_channel_counters,
	lbls_words_if.sink words,
	output logic [lbls_pkg::NUM_CHANNELS-1:0][lbls_pkg::COUNTER_WIDTH-1:0] counts
);

	// ones in this cycle's inverted word widened for the add
	logic [lbls_pkg::NUM_CHANNELS-1:0][lbls_pkg::COUNTER_WIDTH-1:0] word_ones;

	always_comb begin
		for (int ch = 0; ch < lbls_pkg::NUM_CHANNELS; ch++) begin
			word_ones[ch] = (lbls_pkg::COUNTER_WIDTH)'(
				lbls_pkg::count_ones(words.inverted[ch]));
		end
	end

	// clear wins over the add in the same cycle
	always_ff @(posedge clock) begin
		if (reset || clear_channel_counters) begin
			counts <= '0;
		end else begin
			for (int ch = 0; ch < lbls_pkg::NUM_CHANNELS; ch++) begin
				// wraps at 2^32
				counts[ch] <= counts[ch] + word_ones[ch];
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/lbls_word_conditioner.sv
// first pipeline stage of the bank
// inverts, gates and masks the raw words, counts ones and flags hits
// trigger level is delayed to line up with the ones counts
`default_nettype none

module lbls_word_conditioner (
	input wire logic clock,
	input wire logic reset,
	input wire lbls_pkg::channel_words_t win,
	input wire lbls_pkg::channel_mask_t inversion_mask,
	input wire lbls_pkg::channel_mask_t hit_mask,
	input wire logic gate,
	input wire logic trigger_active,
	lbls_words_if.source words
);

	// inverted word with hit mask and gate applied
	lbls_pkg::channel_words_t gated;
	// first tap of the trigger delay
	logic trigger_delay;

	always_comb begin
		for (int ch = 0; ch < lbls_pkg::NUM_CHANNELS; ch++) begin
			// polarity flip per channel
			words.inverted[ch] = win[ch] ^ {lbls_pkg::WORD_WIDTH{inversion_mask[ch]}};
			// whole word zeroed when channel disabled or gate closed
			gated[ch] = words.inverted[ch] &
				{lbls_pkg::WORD_WIDTH{hit_mask[ch] & gate}};
		end
	end

	// masked word and hit flag, word at edge N shows at N+1
	always_ff @(posedge clock) begin
		if (reset) begin
			words.masked <= '0;
			words.hit <= '0;
		end else begin
			words.masked <= gated;
			for (int ch = 0; ch < lbls_pkg::NUM_CHANNELS; ch++) begin
				words.hit[ch] <= |gated[ch];
			end
		end
	end

	// popcount stage, shows at N+2
	always_ff @(posedge clock) begin
		if (reset) begin
			words.ones <= '0;
		end else begin
			for (int ch = 0; ch < lbls_pkg::NUM_CHANNELS; ch++) begin
				words.ones[ch] <= lbls_pkg::count_ones(words.masked[ch]);
			end
		end
	end

	// two deep trigger delay
	always_ff @(posedge clock) begin
		if (reset) begin
			trigger_delay <= 1'b0;
			words.trigger <= 1'b0;
		end else begin
			trigger_delay <= trigger_active;
			words.trigger <= trigger_delay;
		end
	end

	// disabled or ungated channel never leaks into masked one cycle later
	for (genvar ch = 0; ch < lbls_pkg::NUM_CHANNELS; ch++) begin : g_mask_check
		a_masked_zero: assert property (
			@(posedge clock) disable iff (reset)
			!(hit_mask[ch] && gate) |=> (words.masked[ch] == '0)
		);
	end

endmodule

`default_nettype wire

//--- common/lbls_words_if.sv
// conditioned channel words from the conditioner to the statistics stages
// source on the conditioner side, sink on counters, scaler and tot
`default_nettype none

interface lbls_words_if;

	// zero latency, polarity corrected
	lbls_pkg::channel_words_t inverted;
	// gated by hit mask and gate, one register
	lbls_pkg::channel_words_t masked;
	// popcount of masked, one register later
	lbls_pkg::channel_ones_t ones;
	// per channel nonzero flag, lines up with masked
	lbls_pkg::channel_mask_t hit;
	// trigger level aligned with ones
	logic trigger;

	modport source (
		output inverted, masked, ones, hit, trigger
	);

	modport sink (
		input inverted, masked, ones, hit, trigger
	);

endinterface

`default_nettype wire

//--- common/lbls_pkg.sv
// shared constants and channel array types for one readout bank
// modules reference these by scoped name, lbls_pkg::name
`default_nettype none

package lbls_pkg;

	// channels per bank and deserializer bits per channel per clock
	localparam int NUM_CHANNELS = 12;
	localparam int WORD_WIDTH = 8;

	// popcount of one word, 0 to 8
	localparam int ONES_WIDTH = 4;

	// slow monitoring counters
	localparam int COUNTER_WIDTH = 32;
	// published rate scalers, saturating
	localparam int SCALER_WIDTH = 16;
	// time over threshold, wraps
	localparam int TOT_WIDTH = 8;

	// scaler window in clocks
	// a hardware build runs about 12.5 million here
	localparam int ACCUMULATE_PERIODS = 256;
	localparam int WINDOW_WIDTH = $clog2(ACCUMULATE_PERIODS);

	typedef logic [NUM_CHANNELS-1:0][WORD_WIDTH-1:0] channel_words_t;
	typedef logic [NUM_CHANNELS-1:0][ONES_WIDTH-1:0] channel_ones_t;
	typedef logic [NUM_CHANNELS-1:0] channel_mask_t;

	// number of set bits in one deserializer word
	function automatic logic [ONES_WIDTH-1:0] count_ones(input logic [WORD_WIDTH-1:0] word);
		logic [ONES_WIDTH-1:0] total;
		total = '0;
		for (int b = 0; b < WORD_WIDTH; b++) begin
			total = total + (ONES_WIDTH)'(word[b]);
		end
		return total;
	endfunction

endpackage

`default_nettype wire
